/* hdl/dhcp_lease_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_lease_store (
  input  wire                   clk,
  input  wire                   fsm_rst,
  input  wire                   dhcp_val,
  input  wire dhcp_pkg::ipv4_t  yiaddr,
  input  wire dhcp_pkg::byte_t  msg_type,
  input  wire dhcp_pkg::ipv4_t  net_mask,
  input  wire dhcp_pkg::ipv4_t  router,
  input  wire dhcp_pkg::lease_t lease_time,
  input  wire dhcp_pkg::ipv4_t  srv_id,
  output logic                  lease_held,
  output dhcp_pkg::byte_t       lease_msg_type,
  output dhcp_pkg::ipv4_t       lease_yiaddr,
  output dhcp_pkg::ipv4_t       lease_mask,
  output dhcp_pkg::ipv4_t       lease_router,
  output dhcp_pkg::ipv4_t       lease_srv_id,
  output dhcp_pkg::lease_t      lease_time_out
);

  dhcp_pkg::byte_t  msg_type_q;
  dhcp_pkg::ipv4_t  yiaddr_q;
  dhcp_pkg::ipv4_t  mask_q;
  dhcp_pkg::ipv4_t  router_q;
  dhcp_pkg::ipv4_t  srv_id_q;
  dhcp_pkg::lease_t time_q;
  logic             held_q;
  logic             type_ok;

  assign type_ok = (msg_type == dhcp_pkg::MSG_OFFER) || (msg_type == dhcp_pkg::MSG_ACK);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      held_q     <= 1'b0;
      msg_type_q <= '0;
      yiaddr_q   <= '0;
      mask_q     <= '0;
      router_q   <= '0;
      srv_id_q   <= '0;
      time_q     <= '0;
    end else if (dhcp_val) begin
      msg_type_q <= msg_type;
      yiaddr_q   <= yiaddr;
      mask_q     <= net_mask;
      router_q   <= router;
      srv_id_q   <= srv_id;
      time_q     <= lease_time;
      if (type_ok)
        held_q <= 1'b1;                                 // Other types keep held state
    end
  end

  // New reply shows through during the dhcp_val cycle
  assign lease_held     = held_q || (dhcp_val && type_ok);
  assign lease_msg_type = dhcp_val ? msg_type   : msg_type_q;
  assign lease_yiaddr   = dhcp_val ? yiaddr     : yiaddr_q;
  assign lease_mask     = dhcp_val ? net_mask   : mask_q;
  assign lease_router   = dhcp_val ? router     : router_q;
  assign lease_srv_id   = dhcp_val ? srv_id     : srv_id_q;
  assign lease_time_out = dhcp_val ? lease_time : time_q;

endmodule

`default_nettype wire

/* hdl/dhcp_opt_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_opt_parser (
  input  wire                   clk,
  input  wire                   fsm_rst,
  input  wire                   frame_clr,
  input  wire                   opt_en,
  input  wire                   opt_stb,
  input  wire dhcp_pkg::byte_t  opt_dat,
  input  wire                   opt_last,
  output logic                  opt_end,
  output logic                  opt_bad,
  output logic                  msg_type_seen,
  output dhcp_pkg::byte_t       msg_type,
  output dhcp_pkg::ipv4_t       net_mask,
  output dhcp_pkg::ipv4_t       router,
  output dhcp_pkg::lease_t      lease_time,
  output dhcp_pkg::ipv4_t       srv_id
);

  localparam int VAL_W = 8 * dhcp_pkg::OPT_VAL_BYTES;

  dhcp_pkg::opt_field_t state;
  dhcp_pkg::opt_sel_t   sel;
  dhcp_pkg::byte_t      opt_rem;
  logic [VAL_W-1:0]     opt_sh;
  logic [VAL_W-1:0]     opt_word;
  logic                 opt_act;
  logic                 last_data;
  logic                 skip_kind;

  function automatic dhcp_pkg::opt_sel_t decode(dhcp_pkg::byte_t code);
    case (code)
      dhcp_pkg::OPT_MSG_TYPE   : return dhcp_pkg::SEL_MSG_TYPE;
      dhcp_pkg::OPT_NET_MASK   : return dhcp_pkg::SEL_NET_MASK;
      dhcp_pkg::OPT_ROUTER     : return dhcp_pkg::SEL_ROUTER;
      dhcp_pkg::OPT_LEASE_TIME : return dhcp_pkg::SEL_LEASE;
      dhcp_pkg::OPT_SRV_ID     : return dhcp_pkg::SEL_SRV_ID;
      default                  : return dhcp_pkg::SEL_NONE; // Unknown, skipped
    endcase
  endfunction

  assign opt_act   = opt_en && opt_stb;
  assign opt_word  = {opt_sh[VAL_W-9:0], opt_dat};     // Keeps the last four bytes
  assign last_data = (opt_rem == 8'd1);
  assign skip_kind = (opt_dat == dhcp_pkg::OPT_PAD) || (opt_dat == dhcp_pkg::OPT_END);

  assign opt_end = opt_act && (state == dhcp_pkg::OPT_KIND) && (opt_dat == dhcp_pkg::OPT_END);

  // eof inside an option record
  always_comb begin
    opt_bad = 1'b0;
    if (opt_act && opt_last) begin
      case (state)
        dhcp_pkg::OPT_KIND : opt_bad = !skip_kind;
        dhcp_pkg::OPT_LEN  : opt_bad = (opt_dat != 8'd0);
        dhcp_pkg::OPT_DATA : opt_bad = !last_data;
        default            : opt_bad = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || frame_clr) begin
      state         <= dhcp_pkg::OPT_KIND;
      sel           <= dhcp_pkg::SEL_NONE;
      opt_rem       <= '0;
      msg_type_seen <= 1'b0;
      msg_type      <= '0;                              // Absent options read as zero
      net_mask      <= '0;
      router        <= '0;
      lease_time    <= '0;
      srv_id        <= '0;
    end else if (opt_act) begin
      case (state)
        dhcp_pkg::OPT_KIND : begin
          if (!skip_kind) begin
            sel   <= decode(opt_dat);
            state <= dhcp_pkg::OPT_LEN;
          end
        end
        dhcp_pkg::OPT_LEN : begin
          opt_rem <= opt_dat;
          state   <= (opt_dat == 8'd0) ? dhcp_pkg::OPT_KIND : dhcp_pkg::OPT_DATA;
        end
        dhcp_pkg::OPT_DATA : begin
          opt_rem <= opt_rem - 8'd1;
          if (last_data) begin
            state <= dhcp_pkg::OPT_KIND;
            case (sel)
              dhcp_pkg::SEL_MSG_TYPE : begin
                msg_type      <= opt_word[7:0];
                msg_type_seen <= 1'b1;
              end
              dhcp_pkg::SEL_NET_MASK : net_mask   <= opt_word;
              dhcp_pkg::SEL_ROUTER   : router     <= opt_word;
              dhcp_pkg::SEL_LEASE    : lease_time <= opt_word;
              dhcp_pkg::SEL_SRV_ID   : srv_id     <= opt_word;
              default                : ;
            endcase
          end
        end
        default : state <= dhcp_pkg::OPT_KIND;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (opt_act) begin
      if (state == dhcp_pkg::OPT_LEN)
        opt_sh <= '0;                                   // Zero-extends short values
      else if (state == dhcp_pkg::OPT_DATA)
        opt_sh <= opt_word;
    end
  end

  a_state_legal : assert property (@(posedge clk) disable iff (fsm_rst)
    state inside {dhcp_pkg::OPT_KIND, dhcp_pkg::OPT_LEN, dhcp_pkg::OPT_DATA});

endmodule

`default_nettype wire

/* hdl/dhcp_pkg.sv */
`default_nettype none

package dhcp_pkg;

  // --------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;
  typedef logic [31:0] lease_t;    // Seconds
  typedef logic [10:0] byte_cnt_t; // Offset in frame, up to 1500 bytes

  typedef enum logic [1:0] {
    OPT_KIND,
    OPT_LEN,
    OPT_DATA
  } opt_field_t;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_MSG_TYPE,
    SEL_NET_MASK,
    SEL_ROUTER,
    SEL_LEASE,
    SEL_SRV_ID
  } opt_sel_t;

  // --------------------------------------------------------------------
  // UDP ports and fixed header layout
  // --------------------------------------------------------------------
  localparam port_t DHCP_SRV_PORT = 16'd67;
  localparam port_t DHCP_CLI_PORT = 16'd68;

  localparam int DHCP_OP_OFFSET     = 0;
  localparam int DHCP_XID_OFFSET    = 4;
  localparam int DHCP_YIADDR_OFFSET = 16;
  localparam int DHCP_HDR_LEN       = 236;
  localparam int DHCP_COOKIE_OFFSET = DHCP_HDR_LEN;           // Cookie follows header
  localparam int DHCP_OPT_OFFSET    = DHCP_COOKIE_OFFSET + 4;

  localparam logic [31:0] DHCP_COOKIE   = 32'h6382_5363;
  localparam byte_t       DHCP_OP_REPLY = 8'd2;

  // --------------------------------------------------------------------
  // Option codes and message types
  // --------------------------------------------------------------------
  localparam byte_t OPT_PAD        = 8'd0;
  localparam byte_t OPT_NET_MASK   = 8'd1;
  localparam byte_t OPT_ROUTER     = 8'd3;
  localparam byte_t OPT_LEASE_TIME = 8'd51;
  localparam byte_t OPT_MSG_TYPE   = 8'd53;
  localparam byte_t OPT_SRV_ID     = 8'd54;
  localparam byte_t OPT_END        = 8'd255;

  localparam byte_t MSG_OFFER = 8'd2;
  localparam byte_t MSG_ACK   = 8'd5;

  localparam int OPT_VAL_BYTES = 4; // Option value register width in bytes

endpackage

`default_nettype wire

/* hdl/dhcp_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_rx (
  input  wire                   clk,
  input  wire                   fsm_rst,
  input  wire                   rx_val,
  input  wire                   rx_sof,
  input  wire                   rx_eof,
  input  wire dhcp_pkg::byte_t  rx_dat,
  input  wire dhcp_pkg::port_t  rx_src_port,
  input  wire dhcp_pkg::port_t  rx_dst_port,
  input  wire dhcp_pkg::xid_t   cfg_xid,
  output logic                  dhcp_val,
  output logic                  dhcp_err,
  output dhcp_pkg::ipv4_t       yiaddr,
  output logic                  opt_en,
  output dhcp_pkg::byte_t       opt_dat,
  output logic                  opt_stb,
  output logic                  frame_clr,
  input  wire                   opt_end,
  input  wire                   opt_bad,
  input  wire                   msg_type_seen
);

  dhcp_pkg::byte_cnt_t byte_cnt;
  dhcp_pkg::byte_cnt_t cur_off;
  dhcp_pkg::byte_t     op;
  dhcp_pkg::xid_t      xid;
  logic [31:0]         cookie;
  logic                receiving;
  logic                port_ok;
  logic                start;
  logic                restart;
  logic                take;
  logic                fin;
  logic                cookie_ok;
  logic                val_now;
  logic                err_now;

  function automatic logic in_word(dhcp_pkg::byte_cnt_t off, int base);
    return (off >= dhcp_pkg::byte_cnt_t'(base)) && (off < dhcp_pkg::byte_cnt_t'(base + 4));
  endfunction

  assign port_ok = (rx_src_port == dhcp_pkg::DHCP_SRV_PORT) &&
                   (rx_dst_port == dhcp_pkg::DHCP_CLI_PORT);
  assign start   = rx_val && rx_sof && port_ok;
  assign restart = rx_val && rx_sof && receiving;            // New sof mid-frame
  assign take    = start || (rx_val && receiving && !rx_sof);
  assign cur_off = start ? '0 : byte_cnt;

  assign opt_stb = take;
  assign opt_dat = rx_dat;

  // --------------------------------------------------------------------
  // Frame verdict
  // --------------------------------------------------------------------
  assign cookie_ok = (cookie == dhcp_pkg::DHCP_COOKIE);
  assign fin       = take && (opt_end || opt_bad || rx_eof);
  assign val_now   = take && opt_end && cookie_ok && msg_type_seen &&
                     (op == dhcp_pkg::DHCP_OP_REPLY) && (xid == cfg_xid);
  assign err_now   = take && ((opt_end && !cookie_ok) || opt_bad || (rx_eof && !opt_end));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      receiving <= 1'b0;
      opt_en    <= 1'b0;
      byte_cnt  <= '0;
      frame_clr <= 1'b0;
      dhcp_val  <= 1'b0;
      dhcp_err  <= 1'b0;
    end else begin
      dhcp_val  <= val_now;
      dhcp_err  <= err_now;
      frame_clr <= fin || restart;
      if (take) begin
        receiving <= 1'b1;
        byte_cnt  <= cur_off + 11'd1;
        if (start)
          opt_en <= 1'b0;
        else if (cur_off == dhcp_pkg::byte_cnt_t'(dhcp_pkg::DHCP_OPT_OFFSET - 1))
          opt_en <= 1'b1;                                    // Options from next byte
      end
      if (fin || (restart && !port_ok)) begin
        receiving <= 1'b0;                                   // Rest of frame ignored
        opt_en    <= 1'b0;
      end
    end
  end

  // Header fields, shifted in MSB first
  always_ff @(posedge clk) begin
    if (take) begin
      if (cur_off == dhcp_pkg::byte_cnt_t'(dhcp_pkg::DHCP_OP_OFFSET))
        op <= rx_dat;
      if (in_word(cur_off, dhcp_pkg::DHCP_XID_OFFSET))
        xid <= {xid[23:0], rx_dat};
      if (in_word(cur_off, dhcp_pkg::DHCP_YIADDR_OFFSET))
        yiaddr <= {yiaddr[23:0], rx_dat};
      if (in_word(cur_off, dhcp_pkg::DHCP_COOKIE_OFFSET))
        cookie <= {cookie[23:0], rx_dat};
    end
  end

  a_val_err_excl : assert property (@(posedge clk) disable iff (fsm_rst)
    !(dhcp_val && dhcp_err));

  a_opt_en_in_frame : assert property (@(posedge clk) disable iff (fsm_rst)
    opt_en |-> receiving);

endmodule

`default_nettype wire

/* hdl/dhcp_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_top (
  input  wire                   clk,
  input  wire                   fsm_rst,
  input  wire                   rx_val,
  input  wire                   rx_sof,
  input  wire                   rx_eof,
  input  wire dhcp_pkg::byte_t  rx_dat,
  input  wire dhcp_pkg::port_t  rx_src_port,
  input  wire dhcp_pkg::port_t  rx_dst_port,
  input  wire dhcp_pkg::xid_t   cfg_xid,
  output logic                  dhcp_val,
  output logic                  dhcp_err,
  output logic                  lease_held,
  output dhcp_pkg::byte_t       lease_msg_type,
  output dhcp_pkg::ipv4_t       lease_yiaddr,
  output dhcp_pkg::ipv4_t       lease_mask,
  output dhcp_pkg::ipv4_t       lease_router,
  output dhcp_pkg::ipv4_t       lease_srv_id,
  output dhcp_pkg::lease_t      lease_time
);

  logic             opt_en;
  logic             opt_stb;
  logic             frame_clr;
  logic             opt_end;
  logic             opt_bad;
  logic             msg_type_seen;
  dhcp_pkg::byte_t  opt_dat;
  dhcp_pkg::ipv4_t  yiaddr;
  dhcp_pkg::byte_t  msg_type;
  dhcp_pkg::ipv4_t  net_mask;
  dhcp_pkg::ipv4_t  router;
  dhcp_pkg::ipv4_t  srv_id;
  dhcp_pkg::lease_t opt_lease_time;

  dhcp_rx u_rx (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .rx_val        (rx_val),
    .rx_sof        (rx_sof),
    .rx_eof        (rx_eof),
    .rx_dat        (rx_dat),
    .rx_src_port   (rx_src_port),
    .rx_dst_port   (rx_dst_port),
    .cfg_xid       (cfg_xid),
    .dhcp_val      (dhcp_val),
    .dhcp_err      (dhcp_err),
    .yiaddr        (yiaddr),
    .opt_en        (opt_en),
    .opt_dat       (opt_dat),
    .opt_stb       (opt_stb),
    .frame_clr     (frame_clr),
    .opt_end       (opt_end),
    .opt_bad       (opt_bad),
    .msg_type_seen (msg_type_seen)
  );

  dhcp_opt_parser u_opt_parser (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .frame_clr     (frame_clr),
    .opt_en        (opt_en),
    .opt_stb       (opt_stb),
    .opt_dat       (opt_dat),
    .opt_last      (rx_eof),
    .opt_end       (opt_end),
    .opt_bad       (opt_bad),
    .msg_type_seen (msg_type_seen),
    .msg_type      (msg_type),
    .net_mask      (net_mask),
    .router        (router),
    .lease_time    (opt_lease_time),
    .srv_id        (srv_id)
  );

  dhcp_lease_store u_lease_store (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .dhcp_val       (dhcp_val),
    .yiaddr         (yiaddr),
    .msg_type       (msg_type),
    .net_mask       (net_mask),
    .router         (router),
    .lease_time     (opt_lease_time),
    .srv_id         (srv_id),
    .lease_held     (lease_held),
    .lease_msg_type (lease_msg_type),
    .lease_yiaddr   (lease_yiaddr),
    .lease_mask     (lease_mask),
    .lease_router   (lease_router),
    .lease_srv_id   (lease_srv_id),
    .lease_time_out (lease_time)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module dhcp_rx_tb -o sim_dhcp_rx

out=$(./obj_dir/sim_dhcp_rx)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

/* sim/dhcp_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_checker (
  input  wire                   clk,
  input  wire                   fsm_rst,
  input  wire                   dhcp_val,
  input  wire                   dhcp_err,
  input  wire                   lease_held,
  input  wire dhcp_pkg::byte_t  lease_msg_type,
  input  wire dhcp_pkg::ipv4_t  lease_yiaddr,
  input  wire dhcp_pkg::ipv4_t  lease_mask,
  input  wire dhcp_pkg::ipv4_t  lease_router,
  input  wire dhcp_pkg::ipv4_t  lease_srv_id,
  input  wire dhcp_pkg::lease_t lease_time,
  input  wire                   chk_arm,
  input  wire [1:0]             exp_kind,
  input  wire                   exp_held,
  input  wire dhcp_pkg::byte_t  exp_msg_type,
  input  wire dhcp_pkg::ipv4_t  exp_yiaddr,
  input  wire dhcp_pkg::ipv4_t  exp_mask,
  input  wire dhcp_pkg::ipv4_t  exp_router,
  input  wire dhcp_pkg::ipv4_t  exp_srv_id,
  input  wire dhcp_pkg::lease_t exp_time,
  output int                    mism_cnt,
  output int                    pulse_cnt
);

  logic arm_d;  // Verdict byte was taken on the previous edge

  initial begin
    mism_cnt  = 0;
    pulse_cnt = 0;
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mism_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (fsm_rst) begin
      arm_d <= 1'b0;
    end else begin
      arm_d <= chk_arm;
      if (arm_d) begin
        check_word("dhcp_val", 32'(dhcp_val), 32'(exp_kind == 2'd1));
        check_word("dhcp_err", 32'(dhcp_err), 32'(exp_kind == 2'd2));
        check_word("lease_held", 32'(lease_held), 32'(exp_held));
        check_word("lease_msg_type", 32'(lease_msg_type), 32'(exp_msg_type));
        check_word("lease_yiaddr", lease_yiaddr, exp_yiaddr);
        check_word("lease_mask", lease_mask, exp_mask);
        check_word("lease_router", lease_router, exp_router);
        check_word("lease_srv_id", lease_srv_id, exp_srv_id);
        check_word("lease_time", lease_time, exp_time);
      end else if (dhcp_val || dhcp_err) begin
        $display("Unexpected pulse on dhcp_val or dhcp_err with no frame verdict due");
        pulse_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/dhcp_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dhcp_rx_tb;

  localparam int N_FRAMES = 40;
  localparam int LIMIT    = N_FRAMES * 300 + 1000;

  logic clk;
  logic fsm_rst;
  logic rx_val;
  logic rx_sof;
  logic rx_eof;
  dhcp_pkg::byte_t  rx_dat;
  dhcp_pkg::port_t  rx_src_port;
  dhcp_pkg::port_t  rx_dst_port;
  dhcp_pkg::xid_t   cfg_xid;
  logic dhcp_val;
  logic dhcp_err;
  logic lease_held;
  dhcp_pkg::byte_t  lease_msg_type;
  dhcp_pkg::ipv4_t  lease_yiaddr;
  dhcp_pkg::ipv4_t  lease_mask;
  dhcp_pkg::ipv4_t  lease_router;
  dhcp_pkg::ipv4_t  lease_srv_id;
  dhcp_pkg::lease_t lease_time;

  // Expected outcome and lease model
  logic             chk_arm;
  logic [1:0]       exp_kind;   // 0 none, 1 dhcp_val, 2 dhcp_err
  logic             exp_held;
  dhcp_pkg::byte_t  exp_msg_type;
  dhcp_pkg::ipv4_t  exp_yiaddr;
  dhcp_pkg::ipv4_t  exp_mask;
  dhcp_pkg::ipv4_t  exp_router;
  dhcp_pkg::ipv4_t  exp_srv_id;
  dhcp_pkg::lease_t exp_time;
  int mism_cnt;
  int pulse_cnt;

  // Frame record
  integer          seed = 32'haa99_7112;
  int              cycle_cnt = 0;
  dhcp_pkg::byte_t frm[$];
  int              n_send;
  dhcp_pkg::port_t rec_src;
  dhcp_pkg::port_t rec_dst;
  dhcp_pkg::byte_t rec_op;
  dhcp_pkg::xid_t  rec_xid;
  dhcp_pkg::ipv4_t rec_yiaddr;
  logic [31:0]     rec_cookie;

  tb_clk_gen u_clk (.clk(clk), .fsm_rst(fsm_rst));

  dhcp_rx_top dut (
    .clk(clk), .fsm_rst(fsm_rst), .rx_val(rx_val), .rx_sof(rx_sof), .rx_eof(rx_eof),
    .rx_dat(rx_dat), .rx_src_port(rx_src_port), .rx_dst_port(rx_dst_port),
    .cfg_xid(cfg_xid), .dhcp_val(dhcp_val), .dhcp_err(dhcp_err),
    .lease_held(lease_held), .lease_msg_type(lease_msg_type),
    .lease_yiaddr(lease_yiaddr), .lease_mask(lease_mask), .lease_router(lease_router),
    .lease_srv_id(lease_srv_id), .lease_time(lease_time)
  );

  dhcp_rx_checker u_chk (
    .clk(clk), .fsm_rst(fsm_rst), .dhcp_val(dhcp_val), .dhcp_err(dhcp_err),
    .lease_held(lease_held), .lease_msg_type(lease_msg_type),
    .lease_yiaddr(lease_yiaddr), .lease_mask(lease_mask), .lease_router(lease_router),
    .lease_srv_id(lease_srv_id), .lease_time(lease_time), .chk_arm(chk_arm),
    .exp_kind(exp_kind), .exp_held(exp_held), .exp_msg_type(exp_msg_type),
    .exp_yiaddr(exp_yiaddr), .exp_mask(exp_mask), .exp_router(exp_router),
    .exp_srv_id(exp_srv_id), .exp_time(exp_time), .mism_cnt(mism_cnt),
    .pulse_cnt(pulse_cnt)
  );

  function automatic int urand(input int m);
    return int'($unsigned($random(seed)) % m);
  endfunction

  task automatic add_opt(input dhcp_pkg::byte_t code, input int len, input logic [31:0] val);
    dhcp_pkg::byte_t b;
    frm.push_back(code);
    frm.push_back(dhcp_pkg::byte_t'(len));
    for (int k = 0; k < len; k++) begin
      b = dhcp_pkg::byte_t'($random(seed));          // Leading bytes beyond four are noise
      if (k >= len - 4)
        b = val[8 * (len - 1 - k) +: 8];
      frm.push_back(b);
    end
  endtask

  //----------------------------------------------------------------------
  // Frame builder; scenario picks the defect
  //----------------------------------------------------------------------
  task automatic build_frame(input int scen);
    dhcp_pkg::byte_t b;
    dhcp_pkg::byte_t mt;
    int end_pos;
    frm.delete();
    rec_src    = dhcp_pkg::DHCP_SRV_PORT;
    rec_dst    = dhcp_pkg::DHCP_CLI_PORT;
    rec_op     = dhcp_pkg::DHCP_OP_REPLY;
    rec_xid    = cfg_xid;
    rec_yiaddr = $random(seed);
    rec_cookie = dhcp_pkg::DHCP_COOKIE;
    mt         = dhcp_pkg::MSG_OFFER;
    case (scen)
      1: mt = dhcp_pkg::MSG_ACK;
      2: rec_cookie = rec_cookie ^ 32'h0000_0100;
      4: begin
        rec_src = dhcp_pkg::DHCP_CLI_PORT;
        rec_dst = dhcp_pkg::DHCP_SRV_PORT;
      end
      5: rec_xid = rec_xid ^ 32'h1;
      6: rec_op = 8'd1;
      7: mt = 8'd6;                                    // NAK
      default: ;
    endcase
    for (int i = 0; i < dhcp_pkg::DHCP_HDR_LEN; i++) begin
      b = dhcp_pkg::byte_t'($random(seed));
      if (i == 0)
        b = rec_op;
      else if (i >= 4 && i < 8)
        b = rec_xid[8 * (7 - i) +: 8];
      else if (i >= 16 && i < 20)
        b = rec_yiaddr[8 * (19 - i) +: 8];
      frm.push_back(b);
    end
    for (int k = 0; k < 4; k++)
      frm.push_back(rec_cookie[8 * (3 - k) +: 8]);
    if (scen == 1) begin                               // Pads, unknown, zero-length, long
      frm.push_back(dhcp_pkg::OPT_PAD);
      add_opt(8'd12, 5, $random(seed));
      add_opt(8'd77, 0, 32'h0);
      add_opt(dhcp_pkg::OPT_NET_MASK, 6, $random(seed));
      frm.push_back(dhcp_pkg::OPT_PAD);
      add_opt(dhcp_pkg::OPT_ROUTER, 2, $random(seed));
      add_opt(dhcp_pkg::OPT_MSG_TYPE, 1, 32'(mt));
      add_opt(dhcp_pkg::OPT_LEASE_TIME, 4, $random(seed));
      add_opt(dhcp_pkg::OPT_SRV_ID, 7, $random(seed));
    end else begin
      add_opt(dhcp_pkg::OPT_MSG_TYPE, 1, 32'(mt));
      add_opt(dhcp_pkg::OPT_NET_MASK, 4, $random(seed));
      add_opt(dhcp_pkg::OPT_ROUTER, 4, $random(seed));
      add_opt(dhcp_pkg::OPT_LEASE_TIME, 4, $random(seed));
      add_opt(dhcp_pkg::OPT_SRV_ID, 4, $random(seed));
    end
    end_pos = frm.size();
    frm.push_back(dhcp_pkg::OPT_END);
    frm.push_back(dhcp_pkg::byte_t'($random(seed)));  // Trailing bytes after END
    frm.push_back(dhcp_pkg::byte_t'($random(seed)));
    n_send = frm.size();
    if (scen == 3)
      n_send = 241 + urand(end_pos - 241);            // Cut inside the option list
    else if (scen == 8)
      n_send = 10 + urand(200);                        // Cut inside the header
  endtask

  //----------------------------------------------------------------------
  // Reference model of the verdict and option values
  //----------------------------------------------------------------------
  function automatic void predict_reply(output logic [1:0] kind, output int vidx,
                                        output dhcp_pkg::byte_t mt, output logic [31:0] mask,
                                        output logic [31:0] rtr, output logic [31:0] lt,
                                        output logic [31:0] sid);
    int          i;
    int          len;
    int          end_idx;
    logic        seen;
    logic [31:0] v;
    kind = 2'd0;
    vidx = n_send - 1;
    mt = '0;
    mask = '0;
    rtr = '0;
    lt = '0;
    sid = '0;
    seen = 1'b0;
    end_idx = -1;
    i = dhcp_pkg::DHCP_OPT_OFFSET;
    while (i < n_send && end_idx < 0) begin
      if (frm[i] == dhcp_pkg::OPT_END) begin
        end_idx = i;
      end else if (frm[i] == dhcp_pkg::OPT_PAD) begin
        i++;
      end else if (i + 1 >= n_send) begin
        i = n_send;
      end else begin
        len = int'(frm[i + 1]);
        if (i + 1 + len >= n_send) begin
          i = n_send;                                  // Record runs past eof
        end else begin
          v = '0;
          for (int k = 0; k < len; k++)
            v = {v[23:0], frm[i + 2 + k]};
          if (len > 0) begin
            case (frm[i])
              dhcp_pkg::OPT_MSG_TYPE: begin
                mt = v[7:0];
                seen = 1'b1;
              end
              dhcp_pkg::OPT_NET_MASK:   mask = v;
              dhcp_pkg::OPT_ROUTER:     rtr = v;
              dhcp_pkg::OPT_LEASE_TIME: lt = v;
              dhcp_pkg::OPT_SRV_ID:     sid = v;
              default: ;
            endcase
          end
          i = i + 2 + len;
        end
      end
    end
    if (rec_src != dhcp_pkg::DHCP_SRV_PORT || rec_dst != dhcp_pkg::DHCP_CLI_PORT) begin
      kind = 2'd0;
    end else if (end_idx < 0) begin
      kind = 2'd2;
    end else begin
      vidx = end_idx;
      if (rec_cookie != dhcp_pkg::DHCP_COOKIE)
        kind = 2'd2;
      else if (rec_op == dhcp_pkg::DHCP_OP_REPLY && rec_xid == cfg_xid && seen)
        kind = 2'd1;
    end
  endfunction

  task automatic send_frame(input int vidx);
    for (int i = 0; i < n_send; i++) begin
      @(negedge clk);
      rx_val      = 1'b1;
      rx_sof      = (i == 0);
      rx_eof      = (i == n_send - 1);
      rx_dat      = frm[i];
      rx_src_port = rec_src;
      rx_dst_port = rec_dst;
      chk_arm     = (i == vidx);
    end
    @(negedge clk);
    rx_val  = 1'b0;
    rx_sof  = 1'b0;
    rx_eof  = 1'b0;
    chk_arm = 1'b0;
    repeat (2 + urand(4)) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [1:0]      kind;
    int              vidx;
    int              scen;
    dhcp_pkg::byte_t mt;
    logic [31:0]     mask;
    logic [31:0]     rtr;
    logic [31:0]     lt;
    logic [31:0]     sid;
    rx_val = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
    rx_dat = '0;
    rx_src_port = '0;
    rx_dst_port = '0;
    cfg_xid = '0;
    chk_arm = 1'b0;
    exp_kind = 2'd0;
    exp_held = 1'b0;
    exp_msg_type = '0;
    exp_yiaddr = '0;
    exp_mask = '0;
    exp_router = '0;
    exp_srv_id = '0;
    exp_time = '0;
    @(negedge clk);
    while (fsm_rst)
      @(negedge clk);
    cfg_xid = $random(seed);
    for (int f = 0; f < N_FRAMES; f++) begin
      scen = (f < 2) ? 8 - f : (f < 9) ? f - 2 : urand(9);  // Header cut and NAK before any lease
      build_frame(scen);
      predict_reply(kind, vidx, mt, mask, rtr, lt, sid);
      exp_kind = kind;
      if (kind == 2'd1) begin
        exp_msg_type = mt;
        exp_yiaddr   = rec_yiaddr;
        exp_mask     = mask;
        exp_router   = rtr;
        exp_srv_id   = sid;
        exp_time     = lt;
        exp_held     = exp_held || mt == dhcp_pkg::MSG_OFFER || mt == dhcp_pkg::MSG_ACK;
      end
      send_frame(vidx);
    end
    repeat (5) @(negedge clk);
    $display("Errors: %0d value mismatches, %0d unexpected pulses", mism_cnt, pulse_cnt);
    if (mism_cnt == 0 && pulse_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic fsm_rst
);

  localparam int PERIOD     = 20;
  localparam int RST_CYCLES = 5;

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  initial begin
    fsm_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/dhcp_pkg.sv
hdl/dhcp_rx.sv
hdl/dhcp_opt_parser.sv
hdl/dhcp_lease_store.sv
hdl/dhcp_rx_top.sv
sim/tb_clk_gen.sv
sim/dhcp_rx_checker.sv
sim/dhcp_rx_tb.sv
